// File: dv/rv_testdata.hex
// Word 0 is N (program words), word 1 is M (retire records)
// Then N instruction words, then M records, one per line: pc rd rd_wen data
30 27
00500093 00308113 002081B3 40118233 // 00 addi x1 | addi x2 | add x3 | sub x4
123452B7 00001317 00302023 00502223 // 10 lui x5 | auipc x6 | sw x3,0 | sw x5,4
00002383 00738433 00402483 FFF00513 // 20 lw x7 | add x8 use | lw x9 | addi x10,-1
00708013 001005B3 00554933 40895993 // 30 addi x0 | add x11 | xor x18 | srai x19
00895A13 0149AAB3 0149BB33 005A9B93 // 40 srli x20 | slt x21 | sltu x22 | slli x23
001BEC33 00FC7C93 00220463 06300613 // 50 or x24 | andi x25 | beq T | squashed
00221463 00154463 06300613 00156463 // 60 bne N | blt T | squashed | bltu N
00A0D463 06300613 00A0F463 00208463 // 70 bge T | squashed | bgeu N | beq N
00209463 06300613 00A0C463 00A0E463 // 80 bne T | squashed | blt N | bltu T
06300613 00155463 00157463 06300613 // 90 squashed | bge N | bgeu T | squashed
008006EF 06300613 0B800713 001707E7 // A0 jal x13 | squashed | addi x14 | jalr x15
06300613 06300613 00D78833 0000006F // B0 squashed | squashed | add x16 | jal x0,0
00000000 01 1 00000005
00000004 02 1 00000008
00000008 03 1 0000000D
0000000C 04 1 00000008
00000010 05 1 12345000
00000014 06 1 00001014
00000018 00 0 00000000
0000001C 00 0 00000000
00000020 07 1 0000000D
00000024 08 1 0000001A
00000028 09 1 12345000
0000002C 0A 1 FFFFFFFF
00000030 00 0 00000000
00000034 0B 1 00000005
00000038 12 1 EDCBAFFF
0000003C 13 1 FFEDCBAF
00000040 14 1 00EDCBAF
00000044 15 1 00000001
00000048 16 1 00000000
0000004C 17 1 00000020
00000050 18 1 00000025
00000054 19 1 00000005
00000058 00 0 00000000
00000060 00 0 00000000
00000064 00 0 00000000
0000006C 00 0 00000000
00000070 00 0 00000000
00000078 00 0 00000000
0000007C 00 0 00000000
00000080 00 0 00000000
00000088 00 0 00000000
0000008C 00 0 00000000
00000094 00 0 00000000
00000098 00 0 00000000
000000A0 0D 1 000000A4
000000A8 0E 1 000000B8
000000AC 0F 1 000000B0
000000B8 10 1 00000154
000000BC 00 0 00000000

// File: project.f
hw/rv_pkg.sv
hw/rv_alu.sv
hw/rv_branch.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_hazard.sv
hw/rv_execute.sv
hw/rv_core.sv
dv/tb_rv_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module tb_rv_core -f project.f -o tb_rv_core_sim &&
  ./obj_dir/tb_rv_core_sim ||
  { echo "build or simulation returned an error"; exit 1; }

// File: dv/tb_rv_core.sv
module tb_rv_core import rv_pkg::*; ();

  // ========================================
  // Test data layout and constants
  // ========================================
  // Buffer address width for the test data words
  localparam int TD_AW = 9;
  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;

  logic            clk = 1'b0;
  logic            reset;
  logic [XLEN-1:0] imem_addr;
  logic [XLEN-1:0] imem_data;
  retire_t         retire;

  // Word 0 holds N and word 1 holds M ahead of the program and records
  logic [31:0] tdata [2**TD_AW];
  int          prog_len;
  int          rec_count;
  int          rec_idx;

  rv_core dut0 (
    .i_clk       (clk),
    .i_reset     (reset),
    .o_imem_addr (imem_addr),
    .i_imem_data (imem_data),
    .o_retire    (retire)
  );

  // Period of 4
  initial begin
    forever #2 clk = ~clk;
  end

  // ========================================
  // Helpers
  // ========================================
  function automatic logic [31:0] word_at(input int pos);
    return tdata[TD_AW'(pos)];
  endfunction

  // Word fetch returns a no-op past the end of the program
  function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] word;
    word = NOP_INSN;
    if ((addr >> 2) < XLEN'(prog_len)) begin
      word = word_at(2 + int'(addr >> 2));
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h at record %0d",
               name, got, exp, rec_idx);
      $display("SIMULATION FAILED");
      $fatal(1, "retire check failed");
    end
  endtask

  // Record holds pc, rd, rd_wen and data
  task automatic check_record(input int idx);
    int          base;
    logic [31:0] exp_wen;
    base    = 2 + prog_len + 4 * idx;
    exp_wen = word_at(base + 2);
    check_value("o_retire.pc", retire.pc, word_at(base));
    check_value("o_retire.rd_wen", XLEN'(retire.rd_wen), exp_wen);
    // rd and data only mean something for a writer
    if (exp_wen[0]) begin
      check_value("o_retire.rd", XLEN'(retire.rd), word_at(base + 1));
      check_value("o_retire.data", retire.data, word_at(base + 3));
    end
  endtask

  // ========================================
  // Instruction memory model
  // ========================================
  // New PC shows after the rising edge and data is ready by the next one
  initial begin
    forever begin
      @(negedge clk);
      imem_data = fetch_word(imem_addr);
    end
  end

  // ========================================
  // Reset, retire checker and end of run
  // ========================================
  initial begin
    reset     = 1'b0;
    imem_data = NOP_INSN;
    rec_idx   = 0;
    $readmemh("dv/rv_testdata.hex", tdata);
    prog_len  = int'(tdata[0]);
    rec_count = int'(tdata[1]);
    if (prog_len <= 0 || rec_count <= 0 ||
        2 + prog_len + 4 * rec_count > 2**TD_AW) begin
      $display("Test data file is missing, empty or too large for the buffer");
      $display("SIMULATION FAILED");
      $fatal(1, "bad test data");
    end
    // Five cycles in reset with release on a falling edge
    repeat (5) @(negedge clk);
    reset = 1'b1;
    // Retire outputs come from flops and are stable at the falling edge
    while (rec_idx < rec_count) begin
      @(negedge clk);
      if (retire.valid) begin
        check_record(rec_idx);
        rec_idx = rec_idx + 1;
      end
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  // Budget scales with program and record count
  initial begin
    int limit;
    wait (reset === 1'b1);
    limit = 8 * (prog_len + rec_count) + 50;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles: retirement stalled at record %0d of %0d",
             limit, rec_idx, rec_count);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

// File: hw/rv_core.sv
module rv_core import rv_pkg::*; (
  input  logic            i_clk,
  input  logic            i_reset,
  output logic [XLEN-1:0] o_imem_addr,
  input  logic [XLEN-1:0] i_imem_data,
  output retire_t         o_retire
);

  logic [XLEN-1:0] pc_q;
  if_id_t          if_id_d, if_id_q;
  id_ex_t          id_ex_d, id_ex_q;
  ex_mem_t         ex_mem_d, ex_mem_q;
  mem_wb_t         mem_wb_d, mem_wb_q;
  logic            if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid;

  ctrl_t           dec_ctrl;
  logic [XLEN-1:0] dec_imm;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            stall;
  logic            flush;
  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;
  redirect_t       redirect;
  logic [XLEN-1:0] mem_fwd;
  logic [XLEN-1:0] wb_val;
  logic [XLEN-1:0] dmem_rdata;
  logic [XLEN-1:0] dmem [DMEM_WORDS];

  // ========================================
  // Fetch
  // ========================================
  assign o_imem_addr = pc_q;

  // Redirect beats stall
  always_ff @(posedge i_clk) begin
    if (!i_reset) begin
      pc_q <= '0;
    end else if (redirect.taken) begin
      pc_q <= redirect.target;
    end else if (!stall) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign if_id_d.insn = i_imem_data;
  assign if_id_d.pc   = pc_q;

  // Flushed slot decodes as zero insn, a no-op
  always_ff @(posedge i_clk) begin
    if (!i_reset || flush) begin
      if_id_q     <= '0;
      if_id_valid <= 1'b0;
    end else if (!stall) begin
      if_id_q     <= if_id_d;
      if_id_valid <= 1'b1;
    end
  end

  // ========================================
  // Decode
  // ========================================
  rv_decoder u_decoder (
    .i_insn (if_id_q.insn),
    .o_ctrl (dec_ctrl),
    .o_imm  (dec_imm)
  );

  // Written from MEM/WB
  rv_regfile u_regfile (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rs1_addr (if_id_q.insn[19:15]),
    .i_rs2_addr (if_id_q.insn[24:20]),
    .i_rd_addr  (mem_wb_q.rd),
    .i_rd_wen   (mem_wb_q.rd_wen),
    .i_rd_data  (mem_wb_q.wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  always_comb begin
    id_ex_d.ctrl     = dec_ctrl;
    id_ex_d.pc       = if_id_q.pc;
    id_ex_d.rs1_addr = if_id_q.insn[19:15];
    id_ex_d.rs2_addr = if_id_q.insn[24:20];
    id_ex_d.rd       = if_id_q.insn[11:7];
    id_ex_d.rs1_data = rs1_data;
    id_ex_d.rs2_data = rs2_data;
    id_ex_d.imm      = dec_imm;
  end

  rv_hazard u_hazard (
    .i_if_id    (if_id_q),
    .i_id_ex    (id_ex_q),
    .i_ex_mem   (ex_mem_q),
    .i_mem_wb   (mem_wb_q),
    .i_redirect (redirect),
    .o_stall    (stall),
    .o_flush    (flush),
    .o_fwd_a    (fwd_a),
    .o_fwd_b    (fwd_b)
  );

  // Bubble carries zero ctrl, so no write, no mem access, no redirect
  always_ff @(posedge i_clk) begin
    if (!i_reset || flush || stall) begin
      id_ex_q     <= '0;
      id_ex_valid <= 1'b0;
    end else begin
      id_ex_q     <= id_ex_d;
      id_ex_valid <= if_id_valid;
    end
  end

  // ========================================
  // Execute
  // ========================================
  // Jumps forward their link value out of MEM
  assign mem_fwd = (ex_mem_q.ctrl.is_jal || ex_mem_q.ctrl.is_jalr) ?
                   ex_mem_q.link : ex_mem_q.alu_result;

  rv_execute u_execute (
    .i_id_ex    (id_ex_q),
    .i_fwd_a    (fwd_a),
    .i_fwd_b    (fwd_b),
    .i_mem_fwd  (mem_fwd),
    .i_wb_fwd   (mem_wb_q.wb_data),
    .o_ex_mem   (ex_mem_d),
    .o_redirect (redirect)
  );

  always_ff @(posedge i_clk) begin
    if (!i_reset) begin
      ex_mem_q     <= '0;
      ex_mem_valid <= 1'b0;
    end else begin
      ex_mem_q     <= ex_mem_d;
      ex_mem_valid <= id_ex_valid;
    end
  end

  // ========================================
  // Memory and writeback
  // ========================================
  // Word addressed, bits above bit 1
  assign dmem_rdata = dmem[ex_mem_q.alu_result[DMEM_AW+1:2]];

  always_ff @(posedge i_clk) begin
    if (ex_mem_valid && ex_mem_q.ctrl.mem_wr) begin
      dmem[ex_mem_q.alu_result[DMEM_AW+1:2]] <= ex_mem_q.store_data;
    end
  end

  // Load data, then link, else ALU
  always_comb begin
    if (ex_mem_q.ctrl.mem_rd) begin
      wb_val = dmem_rdata;
    end else begin
      wb_val = mem_fwd;
    end
  end

  always_comb begin
    mem_wb_d.rd      = ex_mem_q.rd;
    mem_wb_d.rd_wen  = ex_mem_q.ctrl.rd_wen;
    mem_wb_d.pc      = ex_mem_q.pc;
    // Non-writers report zero data
    mem_wb_d.wb_data = ex_mem_q.ctrl.rd_wen ? wb_val : '0;
  end

  always_ff @(posedge i_clk) begin
    if (!i_reset) begin
      mem_wb_q     <= '0;
      mem_wb_valid <= 1'b0;
    end else begin
      mem_wb_q     <= mem_wb_d;
      mem_wb_valid <= ex_mem_valid;
    end
  end

  // Retire report straight from MEM/WB
  always_comb begin
    o_retire.valid  = mem_wb_valid;
    o_retire.pc     = mem_wb_q.pc;
    o_retire.rd     = mem_wb_q.rd;
    o_retire.rd_wen = mem_wb_q.rd_wen;
    o_retire.data   = mem_wb_q.wb_data;
  end

endmodule

// File: hw/rv_execute.sv
module rv_execute import rv_pkg::*; (
  input  id_ex_t          i_id_ex,
  input  fwd_sel_e        i_fwd_a,
  input  fwd_sel_e        i_fwd_b,
  input  logic [XLEN-1:0] i_mem_fwd,
  input  logic [XLEN-1:0] i_wb_fwd,
  output ex_mem_t         o_ex_mem,
  output redirect_t       o_redirect
);

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;

  // One forward mux serves both sources
  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                               input logic [XLEN-1:0] rf_val);
    logic [XLEN-1:0] val;
    case (sel)
      FWD_MEM: val = i_mem_fwd;
      FWD_WB:  val = i_wb_fwd;
      default: val = rf_val;
    endcase
    return val;
  endfunction

  always_comb begin
    rs1_val = fwd_mux(i_fwd_a, i_id_ex.rs1_data);
    rs2_val = fwd_mux(i_fwd_b, i_id_ex.rs2_data);
  end

  // AUIPC takes pc and immediate forms take imm
  assign op_a = i_id_ex.ctrl.op_a_pc  ? i_id_ex.pc  : rs1_val;
  assign op_b = i_id_ex.ctrl.op_b_imm ? i_id_ex.imm : rs2_val;

  rv_alu u_alu (
    .i_a      (op_a),
    .i_b      (op_b),
    .i_op     (i_id_ex.ctrl.alu_op),
    .o_result (alu_result)
  );

  // Branch unit sees the raw forwarded sources rather than the muxed operands
  rv_branch u_branch (
    .i_ctrl     (i_id_ex.ctrl),
    .i_rs1      (rs1_val),
    .i_rs2      (rs2_val),
    .i_pc       (i_id_ex.pc),
    .i_imm      (i_id_ex.imm),
    .o_redirect (o_redirect)
  );

  always_comb begin
    o_ex_mem.ctrl       = i_id_ex.ctrl;
    o_ex_mem.pc         = i_id_ex.pc;
    o_ex_mem.rd         = i_id_ex.rd;
    o_ex_mem.alu_result = alu_result;
    // SW data is the forwarded rs2
    o_ex_mem.store_data = rs2_val;
    o_ex_mem.link       = i_id_ex.pc + 32'd4;
  end

endmodule

// File: hw/rv_hazard.sv
module rv_hazard import rv_pkg::*; (
  input  if_id_t    i_if_id,
  input  id_ex_t    i_id_ex,
  input  ex_mem_t   i_ex_mem,
  input  mem_wb_t   i_mem_wb,
  input  redirect_t i_redirect,
  output logic      o_stall,
  output logic      o_flush,
  output fwd_sel_e  o_fwd_a,
  output fwd_sel_e  o_fwd_b
);

  logic [REG_AW-1:0] dec_rs1;
  logic [REG_AW-1:0] dec_rs2;
  logic              mem_hit_ok;
  logic              wb_hit_ok;
  logic              load_use;

  // Source fields of the instruction sitting in decode
  assign dec_rs1 = i_if_id.insn[19:15];
  assign dec_rs2 = i_if_id.insn[24:20];

  // Only real writers to a nonzero rd may forward
  assign mem_hit_ok = i_ex_mem.ctrl.rd_wen && (i_ex_mem.rd != '0);
  assign wb_hit_ok  = i_mem_wb.rd_wen && (i_mem_wb.rd != '0);

  // Memory stage is younger so it wins over writeback
  function automatic fwd_sel_e pick(input logic [REG_AW-1:0] src);
    fwd_sel_e sel;
    if (mem_hit_ok && (i_ex_mem.rd == src)) begin
      sel = FWD_MEM;
    end else if (wb_hit_ok && (i_mem_wb.rd == src)) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_REGFILE;
    end
    return sel;
  endfunction

  always_comb begin
    o_fwd_a = pick(i_id_ex.rs1_addr);
    o_fwd_b = pick(i_id_ex.rs2_addr);
  end

  // Load in execute feeding decode has no data until MEM
  assign load_use = i_id_ex.ctrl.mem_rd && (i_id_ex.rd != '0) &&
                    ((i_id_ex.rd == dec_rs1) || (i_id_ex.rd == dec_rs2));

  // Taken redirect squashes the two younger slots
  assign o_flush = i_redirect.taken;
  assign o_stall = load_use && !o_flush;

endmodule

// File: hw/rv_regfile.sv
module rv_regfile import rv_pkg::*; (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic [REG_AW-1:0] i_rs1_addr,
  input  logic [REG_AW-1:0] i_rs2_addr,
  input  logic [REG_AW-1:0] i_rd_addr,
  input  logic              i_rd_wen,
  input  logic [XLEN-1:0]   i_rd_data,
  output logic [XLEN-1:0]   o_rs1_data,
  output logic [XLEN-1:0]   o_rs2_data
);

  // Storage for x1..x31 only since x0 reads zero
  logic [XLEN-1:0] regs [1:31];

  // Write is blocked while reset is held
  always_ff @(posedge i_clk) begin
    if (i_reset && i_rd_wen && (i_rd_addr != '0)) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // Same-cycle write shows through to cover WB to decode
  function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
    logic [XLEN-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (i_rd_wen && (i_rd_addr == addr)) begin
      data = i_rd_data;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

endmodule

// File: hw/rv_decoder.sv
module rv_decoder import rv_pkg::*; (
  input  logic [XLEN-1:0] i_insn,
  output ctrl_t           o_ctrl,
  output logic [XLEN-1:0] o_imm
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic              alt;
  logic [REG_AW-1:0] rd;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  // funct7 bit 5 picks SUB and SRA
  assign alt    = i_insn[30];
  assign rd     = i_insn[11:7];

  // Shared ALU op table for register and immediate forms
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt_bit,
                                      input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000:  op = (alt_bit && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // Unknown opcodes fall through as a no-op
    o_ctrl        = '0;
    o_ctrl.alu_op = ALU_ADD;
    o_ctrl.funct3 = funct3;
    o_imm         = '0;
    case (opcode)
      OPC_R: begin
        o_ctrl.alu_op = alu_sel(funct3, alt, 1'b1);
        o_ctrl.rd_wen = 1'b1;
      end
      OPC_I: begin
        o_ctrl.alu_op   = alu_sel(funct3, alt, 1'b0);
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.rd_wen   = 1'b1;
        o_imm           = {{20{i_insn[31]}}, i_insn[31:20]};
      end
      OPC_LOAD: begin
        // LW only, address is rs1 + imm
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.mem_rd   = 1'b1;
        o_ctrl.rd_wen   = 1'b1;
        o_imm           = {{20{i_insn[31]}}, i_insn[31:20]};
      end
      OPC_STORE: begin
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.mem_wr   = 1'b1;
        o_imm           = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
      end
      OPC_BRANCH: begin
        o_ctrl.is_branch = 1'b1;
        o_imm = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                 i_insn[11:8], 1'b0};
      end
      OPC_JAL: begin
        o_ctrl.is_jal = 1'b1;
        o_ctrl.rd_wen = 1'b1;
        o_imm = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                 i_insn[30:21], 1'b0};
      end
      OPC_JALR: begin
        o_ctrl.is_jalr = 1'b1;
        o_ctrl.rd_wen  = 1'b1;
        o_imm          = {{20{i_insn[31]}}, i_insn[31:20]};
      end
      OPC_LUI: begin
        o_ctrl.alu_op   = ALU_PASS_B;
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.rd_wen   = 1'b1;
        o_imm           = {i_insn[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        o_ctrl.op_a_pc  = 1'b1;
        o_ctrl.op_b_imm = 1'b1;
        o_ctrl.rd_wen   = 1'b1;
        o_imm           = {i_insn[31:12], 12'b0};
      end
      default: ;
    endcase
    // Writes to x0 are dropped here
    if (rd == '0) begin
      o_ctrl.rd_wen = 1'b0;
    end
  end

endmodule

// File: hw/rv_branch.sv
module rv_branch import rv_pkg::*; (
  input  ctrl_t           i_ctrl,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_imm,
  output redirect_t       o_redirect
);

  logic cond;
  logic [XLEN-1:0] jalr_sum;

  // Condition on forwarded operands
  always_comb begin
    case (i_ctrl.funct3)
      F3_BEQ:  cond = (i_rs1 == i_rs2);
      F3_BNE:  cond = (i_rs1 != i_rs2);
      F3_BLT:  cond = ($signed(i_rs1) < $signed(i_rs2));
      F3_BGE:  cond = ($signed(i_rs1) >= $signed(i_rs2));
      F3_BLTU: cond = (i_rs1 < i_rs2);
      F3_BGEU: cond = (i_rs1 >= i_rs2);
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1 + i_imm;

  // Jumps always redirect, JALR target has bit 0 cleared
  assign o_redirect.taken  = (i_ctrl.is_branch && cond) || i_ctrl.is_jal || i_ctrl.is_jalr;
  assign o_redirect.target = i_ctrl.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : (i_pc + i_imm);

endmodule

// File: hw/rv_alu.sv
module rv_alu import rv_pkg::*; (
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  alu_op_e         i_op,
  output logic [XLEN-1:0] o_result
);

  logic [4:0] shamt;

  // Shift amount from low five bits of b
  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_SLL:    o_result = i_a << shamt;
      // Set-less-than, signed then unsigned
      ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, i_a < i_b};
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SRL:    o_result = i_a >> shamt;
      ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
      ALU_OR:     o_result = i_a | i_b;
      ALU_AND:    o_result = i_a & i_b;
      // LUI passes the upper immediate
      ALU_PASS_B: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

  // ========================================
  // Widths and sizes
  // ========================================
  localparam int XLEN       = 32;
  localparam int REG_AW     = 5;
  localparam int DMEM_WORDS = 1024;
  // Word index width into data memory
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // ========================================
  // RV32I opcodes
  // ========================================
  localparam logic [6:0] OPC_R      = 7'b0110011;
  localparam logic [6:0] OPC_I      = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // Branch conditions in funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // Operand source seen by execute
  typedef enum logic [1:0] {
    FWD_REGFILE, FWD_MEM, FWD_WB
  } fwd_sel_e;

  // ========================================
  // Pipeline payloads
  // ========================================
  typedef struct packed {
    alu_op_e    alu_op;
    logic       op_a_pc;
    logic       op_b_imm;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       mem_rd;
    logic       mem_wr;
    logic       rd_wen;
    logic [2:0] funct3;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] insn;
    logic [XLEN-1:0] pc;
  } if_id_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
  } id_ex_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   store_data;
    logic [XLEN-1:0]   link;
  } ex_mem_t;

  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic              rd_wen;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   wb_data;
  } mem_wb_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    logic              rd_wen;
    logic [XLEN-1:0]   data;
  } retire_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage
